//--- common/fedp_defines.svh
// Build-time sizes for the FEDP special-value path; include wherever lane count or depth is needed
`ifndef FEDP_DEFINES_SVH
`define FEDP_DEFINES_SVH

// --------------------
// Configuration
// --------------------

// Lanes per request, one 16-bit A word and one 16-bit B word each
`define FEDP_LANES 4

// Delay line depth standing in for the multiplier array, at least 1
`define FEDP_PIPE_STAGES 2

// --------------------
// Derived widths
// --------------------

`define FEDP_FMT_W  3
`define FEDP_WORD_W 16
`define FEDP_C_W    32

// Flat width of one request: format, mask, A and B words, FP32 C
`define FEDP_REQ_W (`FEDP_FMT_W + `FEDP_LANES + 2 * `FEDP_WORD_W * `FEDP_LANES + `FEDP_C_W)

`endif

//--- common/fedp_pkg.sv
// Shared types of the FEDP special-value path; import into every module of the pipeline
`include "fedp_defines.svh"

package fedp_pkg;

    // Operand formats, any other code means no format and yields no flags
    typedef enum logic [`FEDP_FMT_W-1:0] {
        FMT_FP16 = 3'd0,
        FMT_BF16 = 3'd1,
        FMT_FP8  = 3'd2,
        FMT_BF8  = 3'd3
    } fmt_t;

    // Raw request as it enters the pipeline
    typedef struct packed {
        fmt_t                                   fmt;
        logic [`FEDP_LANES-1:0]                 mask;
        logic [`FEDP_LANES-1:0][`FEDP_WORD_W-1:0] a;
        logic [`FEDP_LANES-1:0][`FEDP_WORD_W-1:0] b;
        logic [`FEDP_C_W-1:0]                   c;
    } fedp_req_t;

    // Class of one element, at most one of zero/inf/nan is set
    typedef struct packed {
        logic sign;
        logic is_zero;
        logic is_inf;
        logic is_nan;
    } fedp_class_t;

    // Index 0 is the low byte, or the whole word in 16-bit formats
    typedef struct packed {
        fedp_class_t [1:0] a;
        fedp_class_t [1:0] b;
    } lane_class_t;

    typedef struct packed {
        fmt_t                               fmt;
        logic [`FEDP_LANES-1:0]             mask;
        lane_class_t [`FEDP_LANES-1:0]      lanes;
        fedp_class_t                        c;
    } fedp_bundle_t;

    // Exceptional outcome of C + sum(A*B)
    typedef struct packed {
        logic sign;
        logic is_nan;
        logic is_inf;
    } fedp_excep_t;

endpackage

//--- fedp/fedp_classify.sv
// First pipeline stage: classifies every A, B and C element and registers the class bundle
`timescale 1ns/1ps
`include "fedp_defines.svh"

module fedp_classify import fedp_pkg::*; (
    input  logic         clk,
    input  logic         i_arst_n,
    input  logic         i_valid,
    input  fedp_req_t    i_req,
    output logic         o_valid,
    output fedp_bundle_t o_bundle
);

    fedp_bundle_t bundle_d;

    // Generic field decode, E4M3 has no inf and a single NaN pattern
    function automatic fedp_class_t make_class(
        input logic sgn,
        input logic exp_ones,
        input logic exp_zero,
        input logic man_zero,
        input logic man_ones,
        input logic has_inf
    );
        fedp_class_t cls;
        cls.sign    = sgn;
        cls.is_zero = exp_zero & man_zero;
        cls.is_inf  = has_inf & exp_ones & man_zero;
        cls.is_nan  = has_inf ? (exp_ones & ~man_zero) : (exp_ones & man_ones);
        return cls;
    endfunction

    // One 16-bit word as a single element or as two bytes
    function automatic void decode_word(
        input  logic [`FEDP_WORD_W-1:0] w,
        input  fmt_t                    fmt,
        output fedp_class_t [1:0]       cls
    );
        logic [7:0] hb;
        cls = '0;
        case (fmt)
            FMT_FP16: begin
                cls[0] = make_class(w[15], &w[14:10], ~|w[14:10], ~|w[9:0], &w[9:0], 1'b1);
            end
            FMT_BF16: begin
                cls[0] = make_class(w[15], &w[14:7], ~|w[14:7], ~|w[6:0], &w[6:0], 1'b1);
            end
            FMT_FP8: begin
                for (int h = 0; h < 2; h++) begin
                    hb = w[h*8 +: 8];
                    cls[h] = make_class(hb[7], &hb[6:3], ~|hb[6:3], ~|hb[2:0], &hb[2:0], 1'b0);
                end
            end
            FMT_BF8: begin
                for (int h = 0; h < 2; h++) begin
                    hb = w[h*8 +: 8];
                    cls[h] = make_class(hb[7], &hb[6:2], ~|hb[6:2], ~|hb[1:0], &hb[1:0], 1'b1);
                end
            end
            default: begin
                cls = '0;
            end
        endcase
    endfunction

    // --------------------
    // Decode
    // --------------------
    always_comb begin
        bundle_d      = '0;
        bundle_d.fmt  = i_req.fmt;
        bundle_d.mask = i_req.mask;
        for (int l = 0; l < `FEDP_LANES; l++) begin
            decode_word(i_req.a[l], i_req.fmt, bundle_d.lanes[l].a);
            decode_word(i_req.b[l], i_req.fmt, bundle_d.lanes[l].b);
        end
        // Accumulator is always FP32
        bundle_d.c = make_class(i_req.c[31], &i_req.c[30:23], ~|i_req.c[30:23],
                                ~|i_req.c[22:0], &i_req.c[22:0], 1'b1);
    end

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid  <= 1'b0;
            o_bundle <= '0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_bundle <= bundle_d;
            end
        end
    end

endmodule

//--- fedp/fedp_class_delay.sv
// Shift register that holds class bundles for the latency of the multiplier array
`timescale 1ns/1ps
`include "fedp_defines.svh"

module fedp_class_delay import fedp_pkg::*; #(
    parameter int DEPTH = `FEDP_PIPE_STAGES
) (
    input  logic         clk,
    input  logic         i_arst_n,
    input  logic         i_valid,
    input  fedp_bundle_t i_bundle,
    output logic         o_valid,
    output fedp_bundle_t o_bundle
);

    fedp_bundle_t     stage_q [DEPTH];
    logic [DEPTH-1:0] vld_q;

    // Every entry moves one stage per clock, no stall
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            vld_q <= '0;
            for (int k = 0; k < DEPTH; k++) begin
                stage_q[k] <= '0;
            end
        end else begin
            vld_q[0]   <= i_valid;
            stage_q[0] <= i_bundle;
            for (int k = 1; k < DEPTH; k++) begin
                vld_q[k]   <= vld_q[k-1];
                stage_q[k] <= stage_q[k-1];
            end
        end
    end

    // Last stage feeds the merger
    assign o_valid  = vld_q[DEPTH-1];
    assign o_bundle = stage_q[DEPTH-1];

endmodule

//--- fedp/fedp_exceptions.sv
// Final stage: folds per-lane product flags and C into one registered exception result
`timescale 1ns/1ps
`include "fedp_defines.svh"

module fedp_exceptions import fedp_pkg::*; (
    input  logic         clk,
    input  logic         i_arst_n,
    input  logic         i_valid,
    input  fedp_bundle_t i_bundle,
    output logic         o_valid,
    output fedp_excep_t  o_excep
);

    logic [`FEDP_LANES-1:0] prod_nan;
    logic [`FEDP_LANES-1:0] prod_inf;
    logic [`FEDP_LANES-1:0] prod_sign;
    logic                   fmt_known;
    logic                   is_8bit;
    logic                   has_pos;
    logic                   has_neg;
    logic                   res_nan;
    fedp_excep_t            excep_d;

    // Undefined format codes silence every flag, C included
    always_comb begin
        case (i_bundle.fmt)
            FMT_FP16, FMT_BF16: begin
                fmt_known = 1'b1;
                is_8bit   = 1'b0;
            end
            FMT_FP8, FMT_BF8: begin
                fmt_known = 1'b1;
                is_8bit   = 1'b1;
            end
            default: begin
                fmt_known = 1'b0;
                is_8bit   = 1'b0;
            end
        endcase
    end

    // --------------------
    // Per-lane products
    // --------------------
    for (genvar l = 0; l < `FEDP_LANES; l++) begin : g_lane
        lane_class_t lc;
        logic [1:0]  nan_in;
        logic [1:0]  inf_z;
        logic [1:0]  inf_op;
        logic [1:0]  sgn;
        logic [1:0]  sub_inf;
        logic [1:0]  sub_pos;
        logic [1:0]  sub_neg;
        logic        sub_nan;
        logic        sub_add_nan;
        logic        live;

        assign lc   = i_bundle.lanes[l];
        assign live = i_bundle.mask[l] & fmt_known;

        for (genvar j = 0; j < 2; j++) begin : g_sub
            assign nan_in[j]  = lc.a[j].is_nan | lc.b[j].is_nan;
            assign inf_z[j]   = (lc.a[j].is_inf & lc.b[j].is_zero)
                              | (lc.a[j].is_zero & lc.b[j].is_inf);
            assign inf_op[j]  = lc.a[j].is_inf | lc.b[j].is_inf;
            assign sgn[j]     = lc.a[j].sign ^ lc.b[j].sign;
            // A real infinity, not inf*0
            assign sub_inf[j] = inf_op[j] & ~inf_z[j];
            assign sub_pos[j] = sub_inf[j] & ~sgn[j];
            assign sub_neg[j] = sub_inf[j] & sgn[j];
        end

        // Sub-product pair: NaN input, inf*0, or +inf meeting -inf
        assign sub_nan     = (|nan_in) | (|inf_z);
        assign sub_add_nan = (sub_pos[0] & sub_neg[1]) | (sub_neg[0] & sub_pos[1]);

        always_comb begin
            if (is_8bit) begin
                prod_nan[l]  = (sub_nan | sub_add_nan) & live;
                prod_inf[l]  = (|sub_inf) & live;
                prod_sign[l] = (|sub_neg) & ~(|sub_pos);
            end else begin
                // 16-bit formats use index 0 only
                prod_nan[l]  = (nan_in[0] | inf_z[0]) & live;
                prod_inf[l]  = sub_inf[0] & live;
                prod_sign[l] = sgn[0];
            end
        end
    end

    // --------------------
    // Global merge
    // --------------------
    assign has_pos = (|(prod_inf & ~prod_sign))
                   | (i_bundle.c.is_inf & ~i_bundle.c.sign & fmt_known);
    assign has_neg = (|(prod_inf & prod_sign))
                   | (i_bundle.c.is_inf & i_bundle.c.sign & fmt_known);

    // Opposite infinities anywhere in the sum give NaN
    assign res_nan = (|prod_nan) | (i_bundle.c.is_nan & fmt_known) | (has_pos & has_neg);

    assign excep_d.sign   = has_neg & ~has_pos;
    assign excep_d.is_nan = res_nan;
    assign excep_d.is_inf = (has_pos | has_neg) & ~res_nan;

    // Result holds between requests
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid <= 1'b0;
            o_excep <= '0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_excep <= excep_d;
            end
        end
    end

endmodule

//--- verilog/fedp_special_top.sv
// Top of the FEDP special-value path: classifier, delay line and exception merger in series
`timescale 1ns/1ps
`include "fedp_defines.svh"

module fedp_special_top import fedp_pkg::*; (
    input  logic        clk,
    input  logic        i_arst_n,
    input  logic        i_valid,
    input  fedp_req_t   i_req,
    output logic        o_valid,
    output fedp_excep_t o_excep
);

    logic         cls_valid;
    fedp_bundle_t cls_bundle;
    logic         dly_valid;
    fedp_bundle_t dly_bundle;

    // Stage 1, operand classes
    fedp_classify u_classify (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_valid),
        .i_req    (i_req),
        .o_valid  (cls_valid),
        .o_bundle (cls_bundle)
    );

    // Matches the multiplier latency
    fedp_class_delay #(
        .DEPTH (`FEDP_PIPE_STAGES)
    ) u_class_delay (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_valid  (cls_valid),
        .i_bundle (cls_bundle),
        .o_valid  (dly_valid),
        .o_bundle (dly_bundle)
    );

    // Last stage, registered result
    fedp_exceptions u_exceptions (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_valid  (dly_valid),
        .i_bundle (dly_bundle),
        .o_valid  (o_valid),
        .o_excep  (o_excep)
    );

endmodule

//--- tb/tb_fedp_special.sv
// Directed testbench for the FEDP special-value path; build from filelist.f with top tb_fedp_special
`timescale 1ns/1ps
`include "fedp_defines.svh"

module tb_fedp_special import fedp_pkg::*; ();

    localparam int LAT        = `FEDP_PIPE_STAGES + 2;
    localparam int B2B_N      = 8;
    localparam int SINGLE_N   = 38;
    localparam int MAX_CYCLES = 10 + SINGLE_N * (LAT + 3) + B2B_N + LAT + 50;

    logic        clk = 1'b0;
    logic        i_arst_n;
    logic        i_valid;
    fedp_req_t   i_req;
    logic        o_valid;
    fedp_excep_t o_excep;

    int seed         = 45380;
    int cycles       = 0;
    int err_count    = 0;
    int err_base     = 0;
    int test_count   = 0;
    int failed_tests = 0;

    fedp_special_top UUT (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // --------------------
    // Reference model
    // --------------------

    // Element class from raw bits and field widths, E4M3 has no inf
    function automatic fedp_class_t ref_class(input logic [31:0] bits, input int ew,
                                              input int mw, input bit e4m3);
        fedp_class_t cls;
        logic [31:0] e;
        logic [31:0] m;
        logic [31:0] m_max;
        m_max = (32'd1 << mw) - 32'd1;
        e     = (bits >> mw) & ((32'd1 << ew) - 32'd1);
        m     = bits & m_max;
        cls      = '0;
        cls.sign = bits[ew + mw];
        if (e == (32'd1 << ew) - 32'd1) begin
            cls.is_inf = !e4m3 && m == 0;
            cls.is_nan = e4m3 ? (m == m_max) : (m != 0);
        end else begin
            cls.is_zero = (e == 0) && (m == 0);
        end
        return cls;
    endfunction

    // Half h selects the byte in 8-bit formats
    function automatic fedp_class_t elem_class(input fmt_t f, input logic [15:0] w, input int h);
        logic [7:0] hb;
        hb = w[h*8 +: 8];
        case (f)
            FMT_FP16: return ref_class({16'd0, w}, 5, 10, 1'b0);
            FMT_BF16: return ref_class({16'd0, w}, 8, 7, 1'b0);
            FMT_FP8:  return ref_class({24'd0, hb}, 4, 3, 1'b1);
            default:  return ref_class({24'd0, hb}, 5, 2, 1'b0);
        endcase
    endfunction

    function automatic fedp_excep_t ref_excep(input fedp_req_t r);
        fedp_excep_t want;
        fedp_class_t ca;
        fedp_class_t cb;
        fedp_class_t cc;
        logic        nan;
        logic        pos;
        logic        neg;
        logic        inf_z;
        logic        inf_p;
        int          nsub;
        want = '0;
        if (!(r.fmt inside {FMT_FP16, FMT_BF16, FMT_FP8, FMT_BF8})) begin
            return want;
        end
        nsub = (r.fmt == FMT_FP8 || r.fmt == FMT_BF8) ? 2 : 1;
        cc   = ref_class(r.c, 8, 23, 1'b0);
        nan  = cc.is_nan;
        pos  = cc.is_inf & ~cc.sign;
        neg  = cc.is_inf & cc.sign;
        for (int l = 0; l < `FEDP_LANES; l++) begin
            for (int h = 0; h < nsub; h++) begin
                ca    = elem_class(r.fmt, r.a[l], h);
                cb    = elem_class(r.fmt, r.b[l], h);
                inf_z = (ca.is_inf & cb.is_zero) | (ca.is_zero & cb.is_inf);
                inf_p = (ca.is_inf | cb.is_inf) & ~inf_z & r.mask[l];
                nan  |= (ca.is_nan | cb.is_nan | inf_z) & r.mask[l];
                pos  |= inf_p & ~(ca.sign ^ cb.sign);
                neg  |= inf_p & (ca.sign ^ cb.sign);
            end
        end
        want.is_nan = nan | (pos & neg);
        want.is_inf = (pos | neg) & ~want.is_nan;
        want.sign   = neg & ~pos;
        return want;
    endfunction

    // --------------------
    // Stimulus and checks
    // --------------------

    function automatic fedp_req_t base_req(input fmt_t f);
        fedp_req_t r;
        r.fmt  = f;
        r.mask = '1;
        for (int l = 0; l < `FEDP_LANES; l++) begin
            r.a[l] = 16'h3C3C;
            r.b[l] = 16'h3C3C;
        end
        r.c = 32'h3F80_0000;
        return r;
    endfunction

    function automatic fedp_req_t rand_req(input fmt_t f);
        fedp_req_t   r;
        logic [31:0] rnd;
        r.fmt  = f;
        rnd    = $random(seed);
        r.mask = rnd[`FEDP_LANES-1:0];
        for (int l = 0; l < `FEDP_LANES; l++) begin
            rnd = $random(seed);
            // Top exponent bit of each byte cleared keeps every format finite
            r.a[l] = rnd[15:0] & 16'hBFBF;
            r.b[l] = rnd[31:16] & 16'hBFBF;
        end
        rnd = $random(seed);
        r.c = rnd & 32'hBFFF_FFFF;
        return r;
    endfunction

    task automatic check_excep(input string name, input fedp_excep_t got, input fedp_excep_t want);
        if (got !== want) begin
            $display("[ERROR] o_excep in %s: got 0x%h, expected 0x%h", name, got, want);
            err_count++;
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("[ERROR] o_valid in %s: got 0x%h, expected 0x%h", name, got, want);
            err_count++;
        end
    endtask

    task automatic send_and_check(input string name, input fedp_req_t r);
        fedp_excep_t want;
        want = ref_excep(r);
        @(posedge clk);
        i_valid <= 1'b1;
        i_req   <= r;
        @(posedge clk);
        i_valid <= 1'b0;
        @(negedge clk);
        while (o_valid !== 1'b1) begin
            @(negedge clk);
        end
        check_excep(name, o_excep, want);
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (err_count == err_base) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, err_count - err_base);
            failed_tests++;
        end
        err_base = err_count;
    endtask

    // --------------------
    // Tests
    // --------------------

    task automatic reset_quiet();
        repeat (5) begin
            @(negedge clk);
            check_valid("reset_quiet", o_valid, 1'b0);
        end
        @(posedge clk);
        i_arst_n <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_valid("reset_quiet", o_valid, 1'b0);
        end
        end_test("reset_quiet");
    endtask

    task automatic finite_operands();
        for (int i = 0; i < 24; i++) begin
            send_and_check("finite_operands", rand_req(fmt_t'(3'(i % 4))));
        end
        end_test("finite_operands");
    endtask

    task automatic nan_inputs();
        fedp_req_t r;
        r      = base_req(FMT_FP16);
        r.a[0] = 16'h7E01;
        send_and_check("nan_inputs", r);
        r      = base_req(FMT_BF16);
        r.b[1] = 16'h7FC0;
        send_and_check("nan_inputs", r);
        r   = base_req(FMT_FP16);
        r.c = 32'h7FC0_0000;
        send_and_check("nan_inputs", r);
        // NaN in a masked lane
        r         = base_req(FMT_FP16);
        r.a[1]    = 16'h7E01;
        r.mask[1] = 1'b0;
        send_and_check("nan_inputs", r);
        r.fmt  = fmt_t'(3'd6);
        r.mask = '1;
        r.c    = 32'h7FC0_0000;
        send_and_check("nan_inputs", r);
        end_test("nan_inputs");
    endtask

    task automatic inf_times_zero();
        fedp_req_t r;
        r      = base_req(FMT_FP16);
        r.a[0] = 16'h7C00;
        r.b[0] = 16'h0000;
        send_and_check("inf_times_zero", r);
        r      = base_req(FMT_BF16);
        r.a[1] = 16'h0000;
        r.b[1] = 16'hFF80;
        send_and_check("inf_times_zero", r);
        // BF8 lane with -inf in the low half and +inf in the high half
        r      = base_req(FMT_BF8);
        r.a[0] = 16'h7C7C;
        r.b[0] = 16'h3CBC;
        send_and_check("inf_times_zero", r);
        r      = base_req(FMT_FP8);
        r.a[2] = 16'h3C7F;
        send_and_check("inf_times_zero", r);
        r.a[2] = 16'h7E78;
        send_and_check("inf_times_zero", r);
        end_test("inf_times_zero");
    endtask

    task automatic inf_merge();
        fedp_req_t r;
        r                  = base_req(FMT_FP16);
        r.a[0]             = 16'h7C00;
        r.b[0]             = 16'h3C00;
        r.a[`FEDP_LANES-1] = 16'hFC00;
        r.b[`FEDP_LANES-1] = 16'hBC00;
        send_and_check("inf_merge", r);
        r.b[`FEDP_LANES-1] = 16'h3C00;
        send_and_check("inf_merge", r);
        r                  = base_req(FMT_BF16);
        r.a[`FEDP_LANES-1] = 16'hFF80;
        r.b[`FEDP_LANES-1] = 16'h3F80;
        r.c                = 32'hFF80_0000;
        send_and_check("inf_merge", r);
        r   = base_req(FMT_FP8);
        r.c = 32'h7F80_0000;
        send_and_check("inf_merge", r);
        end_test("inf_merge");
    endtask

    // One request per cycle, each result due exactly LAT cycles later
    task automatic back_to_back();
        fedp_req_t   reqs  [B2B_N];
        fedp_excep_t wants [B2B_N];
        for (int i = 0; i < B2B_N; i++) begin
            reqs[i] = rand_req(fmt_t'(3'(i % 4)));
            if (i % 3 == 1) begin
                reqs[i].a[i % `FEDP_LANES] = 16'hFC7C;
            end else if (i % 3 == 2) begin
                reqs[i].c = 32'hFF80_0000;
            end
            wants[i] = ref_excep(reqs[i]);
        end
        for (int cyc = 0; cyc < B2B_N + LAT + 1; cyc++) begin
            @(posedge clk);
            if (cyc < B2B_N) begin
                i_valid <= 1'b1;
                i_req   <= reqs[cyc];
            end else begin
                i_valid <= 1'b0;
            end
            @(negedge clk);
            check_valid("back_to_back", o_valid, cyc >= LAT && cyc < B2B_N + LAT);
            if (cyc >= LAT && cyc < B2B_N + LAT) begin
                check_excep("back_to_back", o_excep, wants[cyc - LAT]);
            end
        end
        end_test("back_to_back");
    endtask

    initial begin
        i_arst_n = 1'b0;
        i_valid  = 1'b0;
        i_req    = '0;
        reset_quiet();
        finite_operands();
        nan_inputs();
        inf_times_zero();
        inf_merge();
        back_to_back();
        $display("Summary: %0d tests run, %0d with mismatches, %0d mismatches in total",
                 test_count, failed_tests, err_count);
        if (err_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+common
common/fedp_pkg.sv
fedp/fedp_classify.sv
fedp/fedp_class_delay.sv
fedp/fedp_exceptions.sv
verilog/fedp_special_top.sv
tb/tb_fedp_special.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the FEDP special-value testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

TOP=tb_fedp_special
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module "$TOP" \
    -f filelist.f -o "sim_$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"sim_$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
